//--- rtl/fixed_point_pkg.sv
////////////////////////////////////////
// Fixed point package
// Signed Q8.24 word, Taylor reciprocal
// constants and the truncating multiply
////////////////////////////////////////

package fixed_point_pkg;

  // Q8.24, 8 integer bits incl. sign
  localparam int FRAC_BITS = 24;
  typedef logic signed [31:0] fixed_t;

  // 1.0 in Q8.24
  localparam fixed_t FX_ONE = 32'sh0100_0000;

  // Taylor terms per exponential
  localparam int NUM_TERMS = 24;
  typedef logic [$clog2(NUM_TERMS)-1:0] term_idx_t;

  // 1/(k+1) rounded to nearest LSB, k = 0 .. NUM_TERMS-1
  localparam fixed_t RECIP_TABLE [NUM_TERMS] = '{
    16777216, 8388608, 5592405, 4194304, 3355443, 2796203,
    2396745,  2097152, 1864135, 1677722, 1525201, 1398101,
    1290555,  1198373, 1118481, 1048576, 986895,  932068,
    883011,   838861,  798915,  762601,  729444,  699051
  };

  // Full 64-bit product, back to Q8.24 by truncation
  function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
    logic signed [63:0] prod;
    prod = 64'(a) * 64'(b);
    return fixed_t'(prod >>> FRAC_BITS);
  endfunction

endpackage

//--- rtl/vector_ctrl_pkg.sv
////////////////////////////////////////
// Vector controller package
// Length type, FSM states, pipeline
// latencies and output beat layout
////////////////////////////////////////

package vector_ctrl_pkg;

  // Vector length and element index
  typedef logic [15:0] vec_len_t;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    INPUT = 2'd1,
    WAIT  = 2'd2
  } ctrl_state_t;

  // Cycle counts, start to done
  localparam int EXP_LATENCY  = fixed_point_pkg::NUM_TERMS + 1;
  localparam int SINH_LATENCY = EXP_LATENCY + 1;
  // Accepting edge to output beat
  localparam int VEC_LATENCY  = SINH_LATENCY + 2;

  // One result beat
  typedef struct packed {
    fixed_point_pkg::fixed_t value;
    vec_len_t                index;
    logic                    last;
  } out_beat_t;

endpackage

//--- rtl/scalar_exp.sv
////////////////////////////////////////
// Scalar exponential unit
// Iterative Taylor series of e^x,
// one term added per clock cycle
////////////////////////////////////////

module scalar_exp (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  fixed_point_pkg::fixed_t x,
  output logic                    done,
  output fixed_point_pkg::fixed_t y
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Iteration control
  logic                       busy;
  fixed_point_pkg::term_idx_t term_idx;
  logic                       last_term;

  // Series datapath
  fixed_point_pkg::fixed_t x_q;
  fixed_point_pkg::fixed_t term;
  fixed_point_pkg::fixed_t acc;
  fixed_point_pkg::fixed_t x_term;
  fixed_point_pkg::fixed_t term_next;
  fixed_point_pkg::fixed_t sum_next;

  ////////////////////////////////////////
  // Term recurrence
  ////////////////////////////////////////

  // Final term of the series
  assign last_term = (term_idx ==
                      fixed_point_pkg::term_idx_t'(fixed_point_pkg::NUM_TERMS - 1));

  // x^(k+1)/(k+1)! from x^k/k!, table lookup instead of a divider
  assign x_term    = fixed_point_pkg::fx_mul(term, x_q);
  assign term_next = fixed_point_pkg::fx_mul(x_term,
                                             fixed_point_pkg::RECIP_TABLE[term_idx]);
  assign sum_next  = acc + term_next;

  // Control, restarts on every start pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      term_idx <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy     <= 1'b1;
        term_idx <= '0;
      end else if (busy) begin
        if (last_term) begin
          // Sum complete, done lands EXP_LATENCY after start
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          term_idx <= term_idx + 1'b1;
        end
      end
    end
  end

  // Series state, seeded with the k = 0 term
  always_ff @(posedge CLK) begin
    if (start) begin
      x_q  <= x;
      term <= fixed_point_pkg::FX_ONE;
      acc  <= fixed_point_pkg::FX_ONE;
    end else if (busy) begin
      term <= term_next;
      acc  <= sum_next;
      // Result held until the next run
      if (last_term) begin
        y <= sum_next;
      end
    end
  end

endmodule

//--- rtl/scalar_sinh.sv
////////////////////////////////////////
// Scalar sinh unit
// Runs e^x and e^-x side by side, then
// registers (e^x - e^-x) / 2
////////////////////////////////////////

module scalar_sinh (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  fixed_point_pkg::fixed_t x,
  output logic                    done,
  output fixed_point_pkg::fixed_t y
);

  // Negated operand for the second exponential
  fixed_point_pkg::fixed_t x_neg;

  // Exponential results
  logic                    done_pos;
  logic                    done_neg;
  fixed_point_pkg::fixed_t exp_pos_y;
  fixed_point_pkg::fixed_t exp_neg_y;

  // Both units finish on the same edge
  logic                    pair_done;
  fixed_point_pkg::fixed_t diff;

  assign x_neg     = -x;
  assign pair_done = done_pos && done_neg;
  assign diff      = exp_pos_y - exp_neg_y;

  // e^x
  scalar_exp exp_pos (
    .CLK  (CLK),
    .RST  (RST),
    .start(start),
    .x    (x),
    .done (done_pos),
    .y    (exp_pos_y)
  );

  // e^-x
  scalar_exp exp_neg (
    .CLK  (CLK),
    .RST  (RST),
    .start(start),
    .x    (x_neg),
    .done (done_neg),
    .y    (exp_neg_y)
  );

  // One extra stage on top of EXP_LATENCY
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      done <= 1'b0;
    end else begin
      done <= pair_done;
    end
  end

  // Halving by arithmetic shift keeps the sign
  always_ff @(posedge CLK) begin
    if (pair_done) begin
      y <= diff >>> 1;
    end
  end

endmodule

//--- rtl/vector_sinh.sv
////////////////////////////////////////
// Vector sinh accelerator, top level
// Latches a length, streams elements
// through the scalar sinh unit one at
// a time and emits indexed beats
////////////////////////////////////////

module vector_sinh (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  input  vector_ctrl_pkg::vec_len_t  size_in,
  input  logic                       data_in_enable,
  input  fixed_point_pkg::fixed_t    data_in,
  output logic                       ready,
  output logic                       data_out_enable,
  output vector_ctrl_pkg::out_beat_t data_out
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Controller state
  vector_ctrl_pkg::ctrl_state_t state;
  vector_ctrl_pkg::vec_len_t    vec_len;
  vector_ctrl_pkg::vec_len_t    elem_idx;

  // Event decodes
  logic accept;
  logic finish;
  logic is_last;

  // Scalar unit interface
  logic                    sinh_start;
  fixed_point_pkg::fixed_t sinh_x;
  logic                    sinh_done;
  fixed_point_pkg::fixed_t sinh_y;

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  // Element taken only while in INPUT
  assign accept  = (state == vector_ctrl_pkg::INPUT) && data_in_enable;
  // Scalar result back while waiting
  assign finish  = (state == vector_ctrl_pkg::WAIT) && sinh_done;
  assign is_last = (elem_idx == vector_ctrl_pkg::vec_len_t'(vec_len - 1'b1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= vector_ctrl_pkg::IDLE;
      vec_len         <= '0;
      elem_idx        <= '0;
      sinh_start      <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // Pulses default low
      sinh_start      <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        vector_ctrl_pkg::IDLE: begin
          // Zero length start ignored
          if (start && (size_in != '0)) begin
            vec_len  <= size_in;
            elem_idx <= '0;
            state    <= vector_ctrl_pkg::INPUT;
          end
        end
        vector_ctrl_pkg::INPUT: begin
          if (accept) begin
            sinh_start <= 1'b1;
            state      <= vector_ctrl_pkg::WAIT;
          end
        end
        vector_ctrl_pkg::WAIT: begin
          // Strobes here are dropped, one element in flight
          if (finish) begin
            data_out_enable <= 1'b1;
            if (is_last) begin
              ready <= 1'b1;
              state <= vector_ctrl_pkg::IDLE;
            end else begin
              elem_idx <= elem_idx + 1'b1;
              state    <= vector_ctrl_pkg::INPUT;
            end
          end
        end
        default: state <= vector_ctrl_pkg::IDLE;
      endcase
    end
  end

  // Operand and output beat registers
  always_ff @(posedge CLK) begin
    if (accept) begin
      sinh_x <= data_in;
    end
    if (finish) begin
      data_out.value <= sinh_y;
      data_out.index <= elem_idx;
      data_out.last  <= is_last;
    end
  end

  // Scalar sinh, restarted for every element
  scalar_sinh sinh0 (
    .CLK  (CLK),
    .RST  (RST),
    .start(sinh_start),
    .x    (sinh_x),
    .done (sinh_done),
    .y    (sinh_y)
  );

endmodule

//--- tests/vector_sinh_assert.sv
////////////////////////////////////////
// Vector sinh checker
// Bound assertions on beat timing,
// result value, index and end of vector
////////////////////////////////////////

module vector_sinh_assert (
  input logic                         CLK,
  input logic                         RST,
  input logic                         start,
  input vector_ctrl_pkg::vec_len_t    size_in,
  input logic                         data_in_enable,
  input fixed_point_pkg::fixed_t      data_in,
  input logic                         ready,
  input logic                         data_out_enable,
  input vector_ctrl_pkg::out_beat_t   data_out
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LAT = vector_ctrl_pkg::VEC_LATENCY;
  // Allowed distance from the real-valued sinh in LSB
  localparam longint TOL = 512;

  // Checker's own view of the controller
  vector_ctrl_pkg::ctrl_state_t model_state;

  // Accepted elements and their operands delayed by LAT
  logic                  accept;
  logic [LAT-1:0]        accept_pipe;
  logic [LAT-1:0] [31:0] x_pipe;

  // Expected vector bookkeeping
  logic                      seen_start;
  vector_ctrl_pkg::vec_len_t exp_len;
  vector_ctrl_pkg::vec_len_t exp_idx;
  logic                      exp_last;
  longint                    exp_value;
  longint                    value_err;

  // sinh(x) from real math scaled to Q8.24
  function automatic longint sinh_ref(fixed_point_pkg::fixed_t x);
    real scale;
    real xr;
    real yr;
    scale = real'(64'd1 << fixed_point_pkg::FRAC_BITS);
    xr    = real'(x) / scale;
    yr    = ($exp(xr) - $exp(-xr)) / 2.0;
    return longint'(yr * scale);
  endfunction

  assign accept    = (model_state == vector_ctrl_pkg::INPUT) && data_in_enable;
  assign exp_last  = (exp_idx == exp_len - 1'b1);
  assign exp_value = sinh_ref(fixed_point_pkg::fixed_t'(x_pipe[LAT-1]));
  assign value_err = longint'(data_out.value) - exp_value;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      model_state <= vector_ctrl_pkg::IDLE;
      accept_pipe <= '0;
      seen_start  <= 1'b0;
      exp_len     <= '0;
      exp_idx     <= '0;
    end else begin
      accept_pipe <= {accept_pipe[LAT-2:0], accept};
      case (model_state)
        vector_ctrl_pkg::IDLE: begin
          // Zero length start never taken
          if (start && (size_in != '0)) begin
            seen_start  <= 1'b1;
            exp_len     <= size_in;
            model_state <= vector_ctrl_pkg::INPUT;
          end
        end
        vector_ctrl_pkg::INPUT: begin
          if (data_in_enable) begin
            model_state <= vector_ctrl_pkg::WAIT;
          end
        end
        vector_ctrl_pkg::WAIT: begin
          // Leaves WAIT on the edge that registers the beat
          if (accept_pipe[LAT-2]) begin
            if (exp_last) begin
              model_state <= vector_ctrl_pkg::IDLE;
            end else begin
              model_state <= vector_ctrl_pkg::INPUT;
            end
          end
        end
        default: model_state <= vector_ctrl_pkg::IDLE;
      endcase
      // Index wraps after the last expected beat
      if (accept_pipe[LAT-1]) begin
        exp_idx <= exp_last ? '0 : exp_idx + 1'b1;
      end
    end
  end

  // Operand history
  always_ff @(posedge CLK) begin
    x_pipe <= {x_pipe[LAT-2:0], data_in};
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  reset_quiet: assert property (@(posedge CLK) disable iff (RST)
    !seen_start |-> (!ready && !data_out_enable))
    else $error("ERR %0t ready,data_out_enable expected 0,0 actual %b,%b",
                $time, ready, data_out_enable);

  beat_timing: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable == accept_pipe[LAT-1])
    else $error("ERR %0t data_out_enable expected %b actual %b",
                $time, accept_pipe[LAT-1], data_out_enable);

  beat_value: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> ((value_err <= TOL) && (value_err >= -TOL)))
    else $error("ERR %0t data_out.value expected %0d actual %0d",
                $time, exp_value, data_out.value);

  beat_index: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> (data_out.index == exp_idx))
    else $error("ERR %0t data_out.index expected %0d actual %0d",
                $time, exp_idx, data_out.index);

  beat_last: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> (data_out.last == exp_last))
    else $error("ERR %0t data_out.last expected %b actual %b",
                $time, exp_last, data_out.last);

  // Ready only together with the final beat
  ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready == (data_out_enable && exp_last))
    else $error("ERR %0t ready expected %b actual %b",
                $time, data_out_enable && exp_last, ready);

endmodule

bind vector_sinh vector_sinh_assert assert0 (
  .CLK            (CLK),
  .RST            (RST),
  .start          (start),
  .size_in        (size_in),
  .data_in_enable (data_in_enable),
  .data_in        (data_in),
  .ready          (ready),
  .data_out_enable(data_out_enable),
  .data_out       (data_out)
);

//--- tests/tb_vector_sinh.sv
////////////////////////////////////////
// Vector sinh testbench
// Random vectors with source gaps and
// stray strobes, checked by assertions
////////////////////////////////////////

module tb_vector_sinh;
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // Stimulus constants
  ////////////////////////////////////////

  localparam int NUM_VECTORS = 10;
  localparam int MAX_LEN     = 12;
  localparam int MAX_GAP     = 5;
  localparam int SEED        = 46739;
  localparam int BEAT_WAIT   = vector_ctrl_pkg::VEC_LATENCY + 4;

  // 4.0 in Q8.24, bound of the input range
  localparam fixed_point_pkg::fixed_t FX_FOUR = 32'sh0400_0000;
  // Steps in [-4, 4], both ends included
  localparam logic [31:0] SPAN = 32'd134217729;

  // Zero, +4, -4, +1 LSB, -1 LSB
  localparam fixed_point_pkg::fixed_t EDGE_VALUES [5] = '{
    32'sh0000_0000, 32'sh0400_0000, 32'shFC00_0000, 32'sh0000_0001, 32'shFFFF_FFFF
  };

  // DUT ports
  logic                       CLK;
  logic                       RST;
  logic                       start;
  vector_ctrl_pkg::vec_len_t  size_in;
  logic                       data_in_enable;
  fixed_point_pkg::fixed_t    data_in;
  logic                       ready;
  logic                       data_out_enable;
  vector_ctrl_pkg::out_beat_t data_out;

  // Run bookkeeping
  vector_ctrl_pkg::vec_len_t lens [NUM_VECTORS];
  int                        total_elems;
  int                        elem_count;
  int                        limit_cycles;

  vector_sinh dut0 (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size_in        (size_in),
    .data_in_enable (data_in_enable),
    .data_in        (data_in),
    .ready          (ready),
    .data_out_enable(data_out_enable),
    .data_out       (data_out)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped");
  endtask

  // Edge values first, then uniform over [-4, 4]
  function automatic fixed_point_pkg::fixed_t pick_value(input int n);
    logic [31:0] step;
    if (n < 5) begin
      return EDGE_VALUES[n];
    end
    step = $urandom % SPAN;
    return fixed_point_pkg::fixed_t'(step) - FX_FOUR;
  endfunction

  // Gap, strobe, then optionally a stray strobe and start while busy
  task automatic drive_element(input fixed_point_pkg::fixed_t value, input bit stray);
    int gap;
    gap = int'($urandom % (MAX_GAP + 1));
    repeat (gap) @(posedge CLK);
    data_in_enable <= 1'b1;
    data_in        <= value;
    @(posedge CLK);
    data_in_enable <= 1'b0;
    if (stray) begin
      @(posedge CLK);
      data_in_enable <= 1'b1;
      data_in        <= pick_value(5);
      start          <= 1'b1;
      size_in        <= vector_ctrl_pkg::vec_len_t'(5);
      @(posedge CLK);
      data_in_enable <= 1'b0;
      start          <= 1'b0;
    end
  endtask

  // Output beat of the element in flight
  task automatic wait_for_beat();
    int waited;
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
    end while (!data_out_enable && (waited < BEAT_WAIT));
    if (!data_out_enable) begin
      report_failure("No output beat appeared after an accepted element");
    end
  endtask

  task automatic run_vector(input vector_ctrl_pkg::vec_len_t len);
    int i;
    // Zero length start and a strobe in IDLE, both ignored
    start          <= 1'b1;
    size_in        <= '0;
    data_in_enable <= 1'b1;
    @(posedge CLK);
    data_in_enable <= 1'b0;
    size_in        <= len;
    @(posedge CLK);
    start <= 1'b0;
    for (i = 0; i < int'(len); i++) begin
      drive_element(pick_value(elem_count), ($urandom % 2) == 1);
      elem_count++;
      wait_for_beat();
      if ((i == int'(len) - 1) && !ready) begin
        report_failure("Ready did not pulse on the last beat of a vector");
      end
    end
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run did not complete", limit_cycles);
    $display("=== FAIL ===");
    $fatal(1, "Timeout");
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int v;
    CLK            = 1'b0;
    RST            = 1'b1;
    start          = 1'b0;
    size_in        = '0;
    data_in_enable = 1'b0;
    data_in        = '0;
    total_elems    = 0;
    elem_count     = 0;
    limit_cycles   = 0;
    void'($urandom(SEED));

    // Short vectors first, then random lengths
    lens[0] = vector_ctrl_pkg::vec_len_t'(1);
    lens[1] = vector_ctrl_pkg::vec_len_t'(2);
    for (v = 2; v < NUM_VECTORS; v++) begin
      lens[v] = vector_ctrl_pkg::vec_len_t'(1 + $urandom % MAX_LEN);
    end
    for (v = 0; v < NUM_VECTORS; v++) begin
      total_elems += int'(lens[v]);
    end
    limit_cycles = total_elems * (vector_ctrl_pkg::VEC_LATENCY + 8) + 200;

    repeat (4) @(posedge CLK);
    RST <= 1'b0;
    // Idle after reset, outputs must stay low
    repeat (3) @(posedge CLK);
    for (v = 0; v < NUM_VECTORS; v++) begin
      run_vector(lens[v]);
    end
    repeat (5) @(posedge CLK);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- files.f
rtl/fixed_point_pkg.sv
rtl/vector_ctrl_pkg.sv
rtl/scalar_exp.sv
rtl/scalar_sinh.sv
rtl/vector_sinh.sv
tests/vector_sinh_assert.sv
tests/tb_vector_sinh.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vector sinh testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f \
  --top-module tb_vector_sinh -Mdir obj_dir -o sim_vector_sinh

./obj_dir/sim_vector_sinh > sim.log 2>&1 || true
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
  exit 0
else
  echo "=== FAIL ==="
  exit 1
fi
